// ==== source/dispatch_pkg.sv ====
package dispatch_pkg;

    // ==================================================================
    // Widths
    // ==================================================================
    localparam int LINE_W        = 256;              // One block line, one AXI beat
    localparam int EXP_W         = 8;                // One exponent
    localparam int EXPS_PER_LINE = LINE_W / EXP_W;   // 32 packed exponents per line
    localparam int DDR_LINE_W    = 26;               // DDR line address from a command
    localparam int TILE_ADDR_W   = 9;                // Tile write address

    // ==================================================================
    // AXI read constants
    // ==================================================================
    // Address layout {page[9], pad[2], line[26], byte[5]}
    localparam int             AXI_ADDR_W      = 42;
    localparam logic [7:0]     AXI_ID_DISPATCH = 8'hDC;
    localparam logic [2:0]     AXI_SIZE_32B    = 3'h5;   // 32 bytes per beat
    localparam logic [1:0]     AXI_BURST_INCR  = 2'b01;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [EXP_W-1:0]  exp_t;

    // AR payload
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;     // Beats minus one
        logic [2:0]            size;
        logic [1:0]            burst;
        logic [7:0]            id;
    } axi_ar_t;

    // R payload
    typedef struct packed {
        line_t data;
        logic  last;
    } axi_r_t;

    // Tile write port, one line per cycle
    typedef struct packed {
        logic                   en;
        logic [TILE_ADDR_W-1:0] addr;
        line_t                  man;
        exp_t                   exp;
    } tile_wr_t;

endpackage

// ==== source/block_buffer.sv ====
`timescale 1ns/1ps

module block_buffer #(
    parameter type T     = logic,
    parameter int  DEPTH = 512
) (
    input  logic                     i_clk,
    input  logic                     i_wr_en,
    input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
    input  T                         i_wr_data,
    input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
    output T                         o_rd_data
);

    T mem [DEPTH];   // Maps to block RAM

    // Write port
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

    // Writer address counters stay inside the buffer
    a_wr_addr_range : assert property (@(posedge i_clk)
        i_wr_en |-> (int'(i_wr_addr) < DEPTH));

endmodule

// ==== source/ddr_burst_reader.sv ====
`timescale 1ns/1ps

module ddr_burst_reader #(
    parameter int         BLOCK_EXP_LINES = 16,
    parameter int         BLOCK_MAN_LINES = 512,
    parameter int         BURST_BEATS     = 16,
    parameter logic [8:0] GDDR6_PAGE_ID   = 9'd2
) (
    input  logic                                 i_clk,
    input  logic                                 i_reset_n,
    input  logic                                 i_start,
    input  logic [dispatch_pkg::DDR_LINE_W-1:0]  i_base_line,    // Held by the top during fetch
    output dispatch_pkg::axi_ar_t                o_axi_ar,
    output logic                                 o_axi_arvalid,
    input  logic                                 i_axi_arready,
    input  dispatch_pkg::axi_r_t                 i_axi_r,
    input  logic                                 i_axi_rvalid,
    output logic                                 o_axi_rready,
    output logic                                 o_exp_wr_en,
    output logic [$clog2(BLOCK_EXP_LINES)-1:0]   o_exp_wr_addr,
    output logic                                 o_man_wr_en,
    output logic [$clog2(BLOCK_MAN_LINES)-1:0]   o_man_wr_addr,
    output dispatch_pkg::line_t                  o_wr_data,
    output logic                                 o_exp_ready,
    output logic                                 o_done
);
    import dispatch_pkg::*;

    localparam int TOTAL_LINES = BLOCK_EXP_LINES + BLOCK_MAN_LINES;
    localparam int CNT_W       = $clog2(TOTAL_LINES);
    localparam int EXP_ADDR_W  = $clog2(BLOCK_EXP_LINES);
    localparam int MAN_ADDR_W  = $clog2(BLOCK_MAN_LINES);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RECV} state_t;

    state_t           state;
    logic [CNT_W-1:0] line_cnt;   // Line within the block, also the burst offset
    logic             rd_fire;
    logic             in_exp;     // Current beat belongs to the packed exponent lines

    assign rd_fire       = i_axi_rvalid && o_axi_rready;
    assign in_exp        = line_cnt < CNT_W'(BLOCK_EXP_LINES);
    assign o_axi_arvalid = (state == ST_REQ);
    assign o_axi_rready  = (state == ST_RECV);

    // AR payload, line_cnt holds still while in ST_REQ
    always_comb begin
        o_axi_ar.addr  = {GDDR6_PAGE_ID, 2'b00, i_base_line + DDR_LINE_W'(line_cnt), 5'b0};
        o_axi_ar.len   = 8'(BURST_BEATS - 1);
        o_axi_ar.size  = AXI_SIZE_32B;
        o_axi_ar.burst = AXI_BURST_INCR;
        o_axi_ar.id    = AXI_ID_DISPATCH;
    end

    // ==================================================================
    // Burst FSM and line counter
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state       <= ST_IDLE;
            line_cnt    <= '0;
            o_exp_wr_en <= 1'b0;
            o_man_wr_en <= 1'b0;
            o_exp_ready <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_exp_wr_en <= rd_fire && in_exp;
            o_man_wr_en <= rd_fire && !in_exp;
            o_exp_ready <= rd_fire && (line_cnt == CNT_W'(BLOCK_EXP_LINES - 1));
            o_done      <= 1'b0;
            case (state)
                ST_IDLE: if (i_start) begin
                    line_cnt <= '0;
                    state    <= ST_REQ;
                end
                ST_REQ: if (i_axi_arready) state <= ST_RECV;   // AR accepted
                ST_RECV: if (i_axi_rvalid) begin
                    line_cnt <= line_cnt + 1'b1;
                    if (i_axi_r.last) begin
                        if (line_cnt == CNT_W'(TOTAL_LINES - 1)) begin
                            state  <= ST_IDLE;   // Whole block in
                            o_done <= 1'b1;
                        end else begin
                            state <= ST_REQ;     // Next burst
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Buffer write payload, split by phase
    always_ff @(posedge i_clk) begin
        if (rd_fire) begin
            o_exp_wr_addr <= EXP_ADDR_W'(line_cnt);
            o_man_wr_addr <= MAN_ADDR_W'(line_cnt - CNT_W'(BLOCK_EXP_LINES));
            o_wr_data     <= i_axi_r.data;
        end
    end

    // ==================================================================
    // AXI checks
    // ==================================================================
    a_ar_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_axi_arvalid && !i_axi_arready |=> o_axi_arvalid && $stable(o_axi_ar));

    // Responder must end each burst on beat BURST_BEATS
    a_rlast_beat : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        rd_fire |-> (i_axi_r.last == ((line_cnt % BURST_BEATS) == BURST_BEATS - 1)));

endmodule

// ==== source/exp_unpacker.sv ====
`timescale 1ns/1ps

module exp_unpacker #(
    parameter int BLOCK_EXP_LINES = 16,
    parameter int BLOCK_MAN_LINES = 512
) (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic                               i_start,
    output logic [$clog2(BLOCK_EXP_LINES)-1:0] o_packed_rd_addr,
    input  dispatch_pkg::line_t                i_packed_rd_data,
    output logic                               o_exp_wr_en,
    output logic [$clog2(BLOCK_MAN_LINES)-1:0] o_exp_wr_addr,
    output dispatch_pkg::exp_t                 o_exp_wr_data,
    output logic                               o_done
);
    import dispatch_pkg::*;

    localparam int PACKED_ADDR_W = $clog2(BLOCK_EXP_LINES);
    localparam int IDX_W         = $clog2(BLOCK_MAN_LINES);
    localparam int SEL_W         = $clog2(EXPS_PER_LINE);   // Byte lane select

    logic             busy;
    logic [IDX_W-1:0] idx;        // Entry being read
    logic             wr_en_q;    // Read data valid
    logic [IDX_W-1:0] wr_idx_q;   // Entry whose packed line is on the read port
    logic [SEL_W-1:0] sel;

    // Packed line holding entry idx
    assign o_packed_rd_addr = PACKED_ADDR_W'(idx >> SEL_W);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy    <= 1'b0;
            idx     <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= busy;
            if (i_start) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                idx <= idx + 1'b1;
                if (idx == IDX_W'(BLOCK_MAN_LINES - 1)) busy <= 1'b0;   // Last entry read
            end
        end
    end

    always_ff @(posedge i_clk) begin
        wr_idx_q <= idx;   // Follows the read latency
    end

    assign sel           = wr_idx_q[SEL_W-1:0];
    assign o_exp_wr_en   = wr_en_q;
    assign o_exp_wr_addr = wr_idx_q;
    assign o_exp_wr_data = i_packed_rd_data[EXP_W*sel +: EXP_W];   // Byte i mod 32
    assign o_done        = wr_en_q && (wr_idx_q == IDX_W'(BLOCK_MAN_LINES - 1));

endmodule

// ==== source/tile_copier.sv ====
`timescale 1ns/1ps

module tile_copier #(
    parameter int BLOCK_MAN_LINES = 512
) (
    input  logic                                 i_clk,
    input  logic                                 i_reset_n,
    input  logic                                 i_start,
    input  logic [$clog2(BLOCK_MAN_LINES+1)-1:0] i_line_count,
    output logic [$clog2(BLOCK_MAN_LINES)-1:0]   o_rd_addr,
    input  dispatch_pkg::line_t                  i_man_rd_data,
    input  dispatch_pkg::exp_t                   i_exp_rd_data,
    output dispatch_pkg::tile_wr_t               o_tile_wr,
    output logic                                 o_done
);
    import dispatch_pkg::*;

    localparam int ADDR_W  = $clog2(BLOCK_MAN_LINES);
    localparam int COUNT_W = $clog2(BLOCK_MAN_LINES + 1);

    logic               busy;
    logic [COUNT_W-1:0] cnt;         // Next line to read
    logic [COUNT_W-1:0] count_q;     // Lines in this DISP
    logic               at_end;
    logic               rd_valid;
    logic               wr_en_q;     // Matches the buffer read latency
    logic [ADDR_W-1:0]  wr_addr_q;

    assign at_end    = (cnt == count_q);
    assign rd_valid  = busy && !at_end;
    assign o_rd_addr = ADDR_W'(cnt);   // Same address to both buffers
    assign o_done    = busy && at_end;   // With the last write, or alone for zero lines

    // ==================================================================
    // Copy counter
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= rd_valid;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (at_end) busy <= 1'b0;
                else        cnt  <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) count_q <= i_line_count;
        wr_addr_q <= o_rd_addr;
    end

    // Tile port, data straight from the buffer read ports
    always_comb begin
        o_tile_wr.en   = wr_en_q;
        o_tile_wr.addr = TILE_ADDR_W'(wr_addr_q);
        o_tile_wr.man  = i_man_rd_data;
        o_tile_wr.exp  = i_exp_rd_data;
    end

    // Command must stay inside the mantissa buffer
    a_count_range : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_start |-> (int'(i_line_count) <= BLOCK_MAN_LINES));

endmodule

// ==== source/dispatcher_top.sv ====
`timescale 1ns/1ps

module dispatcher_top #(
    parameter int         BLOCK_EXP_LINES = 16,
    parameter int         BLOCK_MAN_LINES = 512,
    parameter int         BURST_BEATS     = 16,
    parameter logic [8:0] GDDR6_PAGE_ID   = 9'd2
) (
    input  logic                                i_clk,
    input  logic                                i_reset_n,
    input  logic                                i_fetch_en,
    input  logic [dispatch_pkg::DDR_LINE_W-1:0] i_fetch_addr,      // Block base line
    input  logic                                i_disp_en,
    input  logic [7:0]                          i_disp_man_nv_cnt,
    output logic                                o_fetch_done,
    output logic                                o_disp_done,
    output dispatch_pkg::tile_wr_t              o_tile_wr,
    output dispatch_pkg::axi_ar_t               o_axi_ar,
    output logic                                o_axi_arvalid,
    input  logic                                i_axi_arready,
    input  dispatch_pkg::axi_r_t                i_axi_r,
    input  logic                                i_axi_rvalid,
    output logic                                o_axi_rready
);
    import dispatch_pkg::*;

    localparam int EXP_ADDR_W = $clog2(BLOCK_EXP_LINES);
    localparam int MAN_ADDR_W = $clog2(BLOCK_MAN_LINES);
    localparam int COUNT_W    = $clog2(BLOCK_MAN_LINES + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_DISP} state_t;

    state_t                state;
    logic                  fetch_en_q, disp_en_q;
    logic                  fetch_rise, disp_rise;
    logic                  rd_start, cp_start;
    logic                  rd_done_flag, unpack_done_flag;
    logic [DDR_LINE_W-1:0] base_q;
    logic [7:0]            nv_cnt_q;

    logic                  rd_done, exp_ready, unpack_done, cp_done;
    logic                  exp_wr_en, man_wr_en, unp_wr_en;
    logic [EXP_ADDR_W-1:0] exp_wr_addr, packed_rd_addr;
    logic [MAN_ADDR_W-1:0] man_wr_addr, unp_wr_addr, cp_rd_addr;
    line_t                 wr_data, packed_rd_data, man_rd_data;
    exp_t                  unp_wr_data, exp_rd_data;

    assign fetch_rise = i_fetch_en && !fetch_en_q;
    assign disp_rise  = i_disp_en && !disp_en_q;

    // ==================================================================
    // Command FSM
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state            <= ST_IDLE;
            fetch_en_q       <= 1'b0;
            disp_en_q        <= 1'b0;
            rd_start         <= 1'b0;
            cp_start         <= 1'b0;
            rd_done_flag     <= 1'b0;
            unpack_done_flag <= 1'b0;
            o_fetch_done     <= 1'b0;
            o_disp_done      <= 1'b0;
        end else begin
            fetch_en_q   <= i_fetch_en;   // Edges tracked in every state
            disp_en_q    <= i_disp_en;
            rd_start     <= 1'b0;
            cp_start     <= 1'b0;
            o_fetch_done <= 1'b0;
            o_disp_done  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fetch_rise) begin   // Fetch wins a tie
                        state            <= ST_FETCH;
                        rd_start         <= 1'b1;
                        rd_done_flag     <= 1'b0;
                        unpack_done_flag <= 1'b0;
                    end else if (disp_rise) begin
                        state    <= ST_DISP;
                        cp_start <= 1'b1;
                    end
                end
                ST_FETCH: begin
                    if (rd_done)     rd_done_flag     <= 1'b1;
                    if (unpack_done) unpack_done_flag <= 1'b1;
                    if (rd_done_flag && unpack_done_flag) begin
                        o_fetch_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                ST_DISP: if (cp_done) begin
                    o_disp_done <= 1'b1;
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command fields captured on the accepted edge
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && fetch_rise) base_q   <= i_fetch_addr;
        if (state == ST_IDLE && disp_rise)  nv_cnt_q <= i_disp_man_nv_cnt;
    end

    // ==================================================================
    // Datapath
    // ==================================================================
    ddr_burst_reader #(
        .BLOCK_EXP_LINES (BLOCK_EXP_LINES),
        .BLOCK_MAN_LINES (BLOCK_MAN_LINES),
        .BURST_BEATS     (BURST_BEATS),
        .GDDR6_PAGE_ID   (GDDR6_PAGE_ID)
    ) u_reader (
        .i_clk (i_clk), .i_reset_n (i_reset_n),
        .i_start (rd_start), .i_base_line (base_q),
        .o_axi_ar (o_axi_ar), .o_axi_arvalid (o_axi_arvalid), .i_axi_arready (i_axi_arready),
        .i_axi_r (i_axi_r), .i_axi_rvalid (i_axi_rvalid), .o_axi_rready (o_axi_rready),
        .o_exp_wr_en (exp_wr_en), .o_exp_wr_addr (exp_wr_addr),
        .o_man_wr_en (man_wr_en), .o_man_wr_addr (man_wr_addr),
        .o_wr_data (wr_data), .o_exp_ready (exp_ready), .o_done (rd_done)
    );

    block_buffer #(.T(line_t), .DEPTH(BLOCK_EXP_LINES)) u_packed_buf (
        .i_clk (i_clk), .i_wr_en (exp_wr_en), .i_wr_addr (exp_wr_addr), .i_wr_data (wr_data),
        .i_rd_addr (packed_rd_addr), .o_rd_data (packed_rd_data)
    );

    block_buffer #(.T(line_t), .DEPTH(BLOCK_MAN_LINES)) u_man_buf (
        .i_clk (i_clk), .i_wr_en (man_wr_en), .i_wr_addr (man_wr_addr), .i_wr_data (wr_data),
        .i_rd_addr (cp_rd_addr), .o_rd_data (man_rd_data)
    );

    exp_unpacker #(
        .BLOCK_EXP_LINES (BLOCK_EXP_LINES),
        .BLOCK_MAN_LINES (BLOCK_MAN_LINES)
    ) u_unpacker (
        .i_clk (i_clk), .i_reset_n (i_reset_n), .i_start (exp_ready),
        .o_packed_rd_addr (packed_rd_addr), .i_packed_rd_data (packed_rd_data),
        .o_exp_wr_en (unp_wr_en), .o_exp_wr_addr (unp_wr_addr), .o_exp_wr_data (unp_wr_data),
        .o_done (unpack_done)
    );

    block_buffer #(.T(exp_t), .DEPTH(BLOCK_MAN_LINES)) u_exp_buf (
        .i_clk (i_clk), .i_wr_en (unp_wr_en), .i_wr_addr (unp_wr_addr), .i_wr_data (unp_wr_data),
        .i_rd_addr (cp_rd_addr), .o_rd_data (exp_rd_data)
    );

    // Four mantissa lines per NV
    tile_copier #(.BLOCK_MAN_LINES(BLOCK_MAN_LINES)) u_copier (
        .i_clk (i_clk), .i_reset_n (i_reset_n), .i_start (cp_start),
        .i_line_count (COUNT_W'({nv_cnt_q, 2'b00})), .o_rd_addr (cp_rd_addr),
        .i_man_rd_data (man_rd_data), .i_exp_rd_data (exp_rd_data),
        .o_tile_wr (o_tile_wr), .o_done (cp_done)
    );

endmodule

// ==== dv/ddr_read_model.sv ====
`timescale 1ns/1ps

module ddr_read_model #(
    parameter int BURST_BEATS = 16
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  dispatch_pkg::axi_ar_t i_ar,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output dispatch_pkg::axi_r_t  o_r,
    output logic                  o_rvalid,
    input  logic                  i_rready
);
    import dispatch_pkg::*;

    logic                  busy;     // Burst in flight
    logic [DDR_LINE_W-1:0] line_q;   // First line of the burst
    int                    beat;
    logic                  r_held;   // Beat offered but not taken

    // Byte b of DDR line L is (3L + 5b) mod 256
    function automatic line_t ddr_line(input logic [DDR_LINE_W-1:0] line);
        line_t       d;
        logic [31:0] v;
        for (int b = 0; b < EXPS_PER_LINE; b++) begin
            v = 32'(line) * 3 + b * 5;
            d[8*b +: 8] = v[7:0];
        end
        return d;
    endfunction

    initial begin
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
        busy      = 1'b0;
        line_q    = '0;
        beat      = 0;
        forever begin
            @(posedge i_clk);
            r_held = o_rvalid && !i_rready;
            // Transfers completing on this edge
            if (!i_reset_n) begin
                busy = 1'b0;
                beat = 0;
            end else if (!busy && i_arvalid && o_arready) begin
                busy   = 1'b1;
                line_q = i_ar.addr[30:5];   // Line field of the address
                beat   = 0;
            end else if (busy && o_rvalid && i_rready) begin
                if (beat == BURST_BEATS - 1) busy = 1'b0;   // Burst over
                else beat++;
            end
            #2;
            o_arready = i_reset_n && !busy && ($urandom % 4 != 0);   // Random AR stalls
            if (!r_held) o_rvalid = busy && ($urandom % 3 != 0);     // Random R gaps
            o_r.data = ddr_line(line_q + DDR_LINE_W'(beat));
            o_r.last = (beat == BURST_BEATS - 1);
        end
    end

endmodule

// ==== dv/tb_dispatcher.sv ====
`timescale 1ns/1ps

module tb_dispatcher;
    import dispatch_pkg::*;

    localparam int          EXP_LINES    = 16;
    localparam int          MAN_LINES    = 512;
    localparam int          BEATS        = 16;
    localparam logic [8:0]  PAGE_ID      = 9'd2;
    localparam int          AR_PER_BLOCK = EXP_LINES / BEATS + MAN_LINES / BEATS;   // 33
    localparam int          FETCH_LIMIT  = 20000;   // Cycles
    localparam int          DISP_LIMIT   = 2000;
    localparam logic [31:0] SEED         = 32'h3e91_825b;

    logic                  i_clk;
    logic                  i_reset_n;
    logic                  i_fetch_en;
    logic [DDR_LINE_W-1:0] i_fetch_addr;
    logic                  i_disp_en;
    logic [7:0]            i_disp_man_nv_cnt;
    logic                  o_fetch_done;
    logic                  o_disp_done;
    tile_wr_t              o_tile_wr;
    axi_ar_t               o_axi_ar;
    logic                  o_axi_arvalid;
    logic                  i_axi_arready;
    axi_r_t                i_axi_r;
    logic                  i_axi_rvalid;
    logic                  o_axi_rready;

    // ==================================================================
    // Scoreboard state
    // ==================================================================
    logic [127:0]          test_name;
    logic [DDR_LINE_W-1:0] cur_base;   // Base of the block held in the buffers
    int                    cyc = 0;
    int                    ar_count;
    int                    wr_count;
    int                    fetch_done_count;
    int                    disp_done_count;
    int                    disp_done_cyc;    // Edge that samples o_disp_done high
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    tests_run = 0;
    int                    writes_total = 0;
    logic                  timed_out = 1'b0;

    dispatcher_top #(
        .BLOCK_EXP_LINES (EXP_LINES),
        .BLOCK_MAN_LINES (MAN_LINES),
        .BURST_BEATS     (BEATS),
        .GDDR6_PAGE_ID   (PAGE_ID)
    ) i_dut (
        .i_clk (i_clk), .i_reset_n (i_reset_n),
        .i_fetch_en (i_fetch_en), .i_fetch_addr (i_fetch_addr),
        .i_disp_en (i_disp_en), .i_disp_man_nv_cnt (i_disp_man_nv_cnt),
        .o_fetch_done (o_fetch_done), .o_disp_done (o_disp_done), .o_tile_wr (o_tile_wr),
        .o_axi_ar (o_axi_ar), .o_axi_arvalid (o_axi_arvalid), .i_axi_arready (i_axi_arready),
        .i_axi_r (i_axi_r), .i_axi_rvalid (i_axi_rvalid), .o_axi_rready (o_axi_rready)
    );

    ddr_read_model #(.BURST_BEATS(BEATS)) u_ddr (
        .i_clk (i_clk), .i_reset_n (i_reset_n),
        .i_ar (o_axi_ar), .i_arvalid (o_axi_arvalid), .o_arready (i_axi_arready),
        .o_r (i_axi_r), .o_rvalid (i_axi_rvalid), .i_rready (o_axi_rready)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;   // 20 ns period
    end

    always @(posedge i_clk) cyc <= cyc + 1;   // Edge counter

    // Byte b of DDR line L is (3L + 5b) mod 256
    function automatic line_t expected_line(input logic [DDR_LINE_W-1:0] line);
        line_t       d;
        logic [31:0] v;
        for (int b = 0; b < 32; b++) begin
            v = 32'(line) * 3 + b * 5;
            d[8*b +: 8] = v[7:0];
        end
        return d;
    endfunction

    // Entry k is byte k mod 32 of packed line base + k / 32
    function automatic exp_t expected_exp(input logic [DDR_LINE_W-1:0] base, input int k);
        logic [31:0] v;
        v = (32'(base) + k / 32) * 3 + (k % 32) * 5;
        return v[7:0];
    endfunction

    task automatic report_value(input string what, input logic [255:0] expected,
                                input logic [255:0] actual);
        value_errors++;
        $display("error %0s: %0s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("failure in %0s: %0s", test_name, msg);
    endtask

    task automatic step();
        @(posedge i_clk);
        #2;   // Inputs change just after the edge
    endtask

    task automatic confirm_quiet_outputs(input string label);
        if (o_axi_arvalid !== 1'b0) report_value({label, " arvalid"}, 0, o_axi_arvalid);
        if (o_axi_rready !== 1'b0) report_value({label, " rready"}, 0, o_axi_rready);
        if (o_fetch_done !== 1'b0) report_value({label, " fetch done"}, 0, o_fetch_done);
        if (o_disp_done !== 1'b0) report_value({label, " disp done"}, 0, o_disp_done);
        if (o_tile_wr.en !== 1'b0) report_value({label, " tile en"}, 0, o_tile_wr.en);
    endtask

    // AR k of a block
    task automatic verify_ar(input int k);
        logic [DDR_LINE_W-1:0] line;
        line = DDR_LINE_W'(cur_base + BEATS * k);
        if (o_axi_ar.addr[41:33] !== PAGE_ID)
            report_value($sformatf("AR %0d page id", k), PAGE_ID, o_axi_ar.addr[41:33]);
        if (o_axi_ar.addr[32:31] !== 2'b00)
            report_value($sformatf("AR %0d pad bits", k), 0, o_axi_ar.addr[32:31]);
        if (o_axi_ar.addr[30:5] !== line)
            report_value($sformatf("AR %0d line", k), line, o_axi_ar.addr[30:5]);
        if (o_axi_ar.addr[4:0] !== 5'd0)
            report_value($sformatf("AR %0d byte bits", k), 0, o_axi_ar.addr[4:0]);
        if (o_axi_ar.len !== 8'(BEATS - 1))
            report_value($sformatf("AR %0d len", k), BEATS - 1, o_axi_ar.len);
        if (o_axi_ar.size !== 3'd5)   // 32 bytes
            report_value($sformatf("AR %0d size", k), 5, o_axi_ar.size);
        if (o_axi_ar.burst !== 2'b01)   // INCR
            report_value($sformatf("AR %0d burst", k), 1, o_axi_ar.burst);
        if (o_axi_ar.id !== AXI_ID_DISPATCH)
            report_value($sformatf("AR %0d id", k), AXI_ID_DISPATCH, o_axi_ar.id);
    endtask

    task automatic compare_tile_write(input int k);
        line_t man_exp;
        exp_t  exp_exp;
        man_exp = expected_line(DDR_LINE_W'(cur_base + EXP_LINES + k));
        exp_exp = expected_exp(cur_base, k);
        if (o_tile_wr.addr !== TILE_ADDR_W'(k))
            report_value($sformatf("tile write %0d addr", k), k, o_tile_wr.addr);
        if (o_tile_wr.man !== man_exp)
            report_value($sformatf("tile write %0d man", k), man_exp, o_tile_wr.man);
        if (o_tile_wr.exp !== exp_exp)
            report_value($sformatf("tile write %0d exp", k), exp_exp, o_tile_wr.exp);
    endtask

    // ==================================================================
    // Monitor sampling at the falling edge
    // ==================================================================
    always @(negedge i_clk) begin
        if (i_reset_n) begin
            if (o_axi_arvalid && i_axi_arready) begin   // AR taken on the next edge
                verify_ar(ar_count);
                ar_count++;
            end
            if (o_tile_wr.en) begin
                compare_tile_write(wr_count);
                wr_count++;
                writes_total++;
            end
            if (o_fetch_done) fetch_done_count++;
            if (o_disp_done) begin
                disp_done_count++;
                disp_done_cyc = cyc + 1;
            end
        end
    end

    task automatic wait_for_done(input bit fetch_side, input int limit);
        int n;
        n = 0;
        while (((fetch_side ? fetch_done_count : disp_done_count) == 0) && n < limit) begin
            step();
            n++;
        end
        if ((fetch_side ? fetch_done_count : disp_done_count) == 0) begin
            report_failure(fetch_side ? "no fetch done pulse before the timeout"
                                      : "no disp done pulse before the timeout");
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input logic [DDR_LINE_W-1:0] base, input int nv, input int count);
        int rise_cyc;
        tests_run++;
        cur_base         = base;
        ar_count         = 0;
        wr_count         = 0;
        fetch_done_count = 0;
        disp_done_count  = 0;
        if (count != 4 * nv) report_failure("record count is not four times man_nv_cnt");
        // FETCH with the enable held high past the done pulse
        i_fetch_addr = base;
        i_fetch_en   = 1'b1;
        repeat (6) step();
        i_disp_man_nv_cnt = 8'(nv);
        i_disp_en         = 1'b1;   // DISP edge while busy
        repeat (3) step();
        i_disp_en = 1'b0;
        wait_for_done(1'b1, FETCH_LIMIT);
        if (timed_out) return;
        repeat (4) step();
        i_fetch_en = 1'b0;
        step();
        if (ar_count != AR_PER_BLOCK) report_value("AR count", AR_PER_BLOCK, ar_count);
        if (fetch_done_count != 1) report_value("fetch done pulses", 1, fetch_done_count);
        if (disp_done_count != 0) report_value("disp done during fetch", 0, disp_done_count);
        if (wr_count != 0) report_value("tile writes during fetch", 0, wr_count);
        // DISP
        i_disp_man_nv_cnt = 8'(nv);
        i_disp_en         = 1'b1;
        rise_cyc          = cyc + 1;   // Edge that samples the rise
        wait_for_done(1'b0, DISP_LIMIT);
        if (timed_out) return;
        repeat (2) step();
        i_disp_en = 1'b0;
        step();
        if (wr_count != count) report_value("tile write count", count, wr_count);
        if (disp_done_count != 1) report_value("disp done pulses", 1, disp_done_count);
        if (disp_done_cyc - rise_cyc != count + 3)
            report_value("disp done latency", count + 3, disp_done_cyc - rise_cyc);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        int                    fd;
        int                    n;
        logic [8*160-1:0]      line_buf;
        logic [127:0]          name;
        logic [DDR_LINE_W-1:0] base;
        int                    nv;
        int                    count;
        void'($urandom(SEED));
        i_reset_n         = 1'b0;
        i_fetch_en        = 1'b0;
        i_fetch_addr      = '0;
        i_disp_en         = 1'b0;
        i_disp_man_nv_cnt = '0;
        test_name         = "reset";
        repeat (16) begin
            step();
            confirm_quiet_outputs("during reset");
        end
        i_reset_n = 1'b1;
        step();
        confirm_quiet_outputs("after reset");

        fd = $fopen("dv/dispatcher_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open dv/dispatcher_tests.txt");
        end else begin
            while (!timed_out && !$feof(fd)) begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                // Comment and blank lines do not give four fields
                if (n > 0 && $sscanf(line_buf, "%s %h %d %d", name, base, nv, count) == 4) begin
                    test_name = name;
                    run_test(base, nv, count);
                end
            end
            $fclose(fd);
        end
        if (tests_run == 0) report_failure("no test records were run");

        $display("%0d tests, %0d tile writes, %0d value errors, %0d other errors",
                 tests_run, writes_total, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dv/dispatcher_tests.txt ====
# test name, DDR base line in hex, man_nv_cnt, expected tile writes
# tile writes are four times man_nv_cnt
small 0000100 2 8
full 0123450 128 512
none 1000000 0 0
odd 3fff00b 37 148
refill 0200321 64 256

// ==== tb.f ====
source/dispatch_pkg.sv
source/block_buffer.sv
source/ddr_burst_reader.sv
source/exp_unpacker.sv
source/tile_copier.sv
source/dispatcher_top.sv
dv/ddr_read_model.sv
dv/tb_dispatcher.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_dispatcher -f tb.f -o sim_dispatcher

out=$(./obj_dir/sim_dispatcher)
echo "$out"

if grep -qx "Simulation completed successfully" <<< "$out"; then
    exit 0
else
    exit 1
fi
